// File: testbench/texelAddressTests.txt
# Columns in hex: widthLog2 heightLog2 clampS clampT s t sXy tXy expectedLod expectedAddress
# s t sXy tXy are S16.15, sXy tXy is the neighbour one step in x and y
8 8 0 0 00002000 00001000 00002040 00001000 0 02040
8 8 0 0 00002000 00001000 00002080 00001000 1 10820
8 8 0 0 00002000 00001000 00002000 00000f00 2 14210
8 8 0 0 00006000 00003000 00005e00 00003080 3 15198
8 8 0 0 00006000 00003000 00006000 00003400 4 1546c
8 8 0 0 00006000 00003000 00005401 00003000 5 1551e
8 8 0 0 00006000 00003000 00006800 00002000 6 15547
8 8 0 0 00006000 00003000 00004000 00003000 7 15551
8 8 0 0 00006000 00003000 00006000 00007000 8 15554
8 8 0 0 ffffff00 00000000 00000100 00000000 3 1501f
6 6 0 0 00006000 00003000 00004000 00003000 5 01551
4 4 0 0 00006000 00003000 00004000 00003000 3 00151
4 4 0 0 ffffe000 0000a000 ffffe000 0000a000 0 0004c
4 4 1 1 ffffe000 0000a000 ffffe000 0000a000 0 000f0
4 4 1 1 00007fff 00000000 00007fff 00000000 0 0000f
4 4 1 0 ffffe000 0000a000 ffffe000 0000a000 0 00040
4 4 0 1 ffffe000 0000a000 ffffe000 0000a000 0 000fc
8 2 0 0 00006000 00003000 00006400 fffff000 4 0056c
0 0 0 0 00006000 00003000 00002000 00007000 0 00000
5 3 1 0 00008000 0001c000 00008000 0001c000 0 0009f
5 3 0 1 0001c000 00030000 0001c000 00030000 0 000f0
6 4 0 0 00005a00 00006c00 00005c00 00006c00 1 004d6
6 4 0 0 00005a00 00006c00 00005600 00006c00 2 0053b
6 4 0 0 00005a00 00006c00 00005a00 00004c00 3 0054d
6 4 0 0 00005a00 00006c00 00006a00 00006c00 4 00552
6 4 0 0 00005a00 00006c00 00003a00 00006c00 5 00555
6 4 0 0 00005a00 00006c00 00009a00 00006c00 6 00556
2 7 0 0 00004000 00002000 00004000 00003000 5 002b9

// File: verilog.f
logic/texturePkg.sv
logic/lodCalculator.sv
logic/texelCoordinate.sv
logic/mipAddress.sv
logic/texelAddressUnit.sv
testbench/texelAddressUnit_props.sv
testbench/texelAddressUnitTb.sv

// File: Makefile
# Verilator simulation of the texel addressing unit
# Any variable can be overridden, for example make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= texelAddressUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= >>> PASS

.PHONY: sim clean

# Build, run from the project root, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F -- '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/texelAddressUnitTb.sv
`timescale 1ns/1ps
/*
 Testbench for the texel addressing unit, vectors come from a text file.
 Configuration changes only after all fragments in flight have left.
 Must run from the project root so the vector file path resolves.
*/
module texelAddressUnitTb;
    import texturePkg::*;

    // One line of the vector file
    typedef struct packed {
        textureConfig_t cfg;
        texFragment_t   frag;
        texelResult_t   expected;
    } testVector_t;

    // Result waiting for its texelValid
    typedef struct packed {
        logic [15:0]  index;
        texelResult_t result;
    } expectEntry_t;

    localparam string testFile = "testbench/texelAddressTests.txt";

    logic           aclk;
    logic           rstN;
    logic           fragValid;
    texFragment_t   frag;
    textureConfig_t texConfig;
    logic           texelValid;
    texelResult_t   texel;

    testVector_t    tests[$];
    expectEntry_t   expectQ[$];
    int             numTests;
    int             passCount;
    int             failCount;
    int             errorCount;
    logic           testsLoaded;
    logic [31:0]    lfsrState;

    texelAddressUnit texelAddressUnit_inst
    (
        .aclk       (aclk),
        .rstN       (rstN),
        .fragValid  (fragValid),
        .frag       (frag),
        .texConfig  (texConfig),
        .texelValid (texelValid),
        .texel      (texel)
    );

    bind texelAddressUnit texelAddressUnit_props texelAddressUnit_props_inst (.*);

    always #5 aclk = ~aclk;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic drawRandomBit(output logic bitOut);
        bitOut = lfsrState[0];
        lfsrState = lfsrNext(lfsrState);
    endtask

    task automatic readTests();
        int                      fd;
        int                      fields;
        int                      lineNo;
        string                   lineText;
        logic [3:0]              wLog;
        logic [3:0]              hLog;
        logic                    clampS;
        logic                    clampT;
        logic [31:0]             s;
        logic [31:0]             t;
        logic [31:0]             sXy;
        logic [31:0]             tXy;
        logic [3:0]              expLod;
        logic [texAddrWidth-1:0] expAddr;
        testVector_t             vec;

        fd = $fopen(testFile, "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file %s", testFile);
            errorCount++;
            return;
        end
        lineNo = 0;
        while ($fgets(lineText, fd) != 0)
        begin
            lineNo++;
            // Blank lines and column notes
            if (lineText.len() < 2 || lineText.getc(0) == "#")
            begin
                continue;
            end
            fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h", wLog, hLog,
                clampS, clampT, s, t, sXy, tXy, expLod, expAddr);
            if (fields != 10)
            begin
                $display("Line %0d of the vector file cannot be parsed", lineNo);
                errorCount++;
            end
            else
            begin
                vec.cfg = '{widthLog2: wLog, heightLog2: hLog, clampS: clampS, clampT: clampT};
                vec.frag = '{st: '{s: s, t: t}, stXy: '{s: sXy, t: tXy}};
                vec.expected = '{lod: expLod, address: expAddr};
                tests.push_back(vec);
            end
        end
        $fclose(fd);
    endtask

    task automatic checkResult();
        expectEntry_t entry;
        logic         testOk;

        if (expectQ.size() == 0)
        begin
            $display("texelValid at %0t ns with no fragment in flight", $time);
            errorCount++;
            return;
        end
        entry = expectQ.pop_front();
        testOk = 1'b1;
        if (texel.lod !== entry.result.lod)
        begin
            $display("MISMATCH at %0t ns: texel.lod expected %0d actual %0d",
                $time, entry.result.lod, texel.lod);
            testOk = 1'b0;
        end
        if (texel.address !== entry.result.address)
        begin
            $display("MISMATCH at %0t ns: texel.address expected %h actual %h",
                $time, entry.result.address, texel.address);
            testOk = 1'b0;
        end
        if (testOk)
        begin
            passCount++;
            $display("Test %0d passed, lod %0d address %h", entry.index, texel.lod,
                texel.address);
        end
        else
        begin
            failCount++;
            $display("Test %0d failed", entry.index);
        end
    endtask

    // Registered outputs are stable at the falling edge
    always @(negedge aclk)
    begin
        if (rstN && texelValid)
        begin
            checkResult();
        end
    end

    // Watchdog, budget of three cycles per vector plus slack
    initial
    begin
        wait (testsLoaded);
        repeat (numTests * 3 + 50) @(posedge aclk);
        $display("Timeout, results still missing after %0d clock periods",
            numTests * 3 + 50);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin : mainSequence
        logic gapA;
        logic gapB;
        logic resetOk;

        aclk = 1'b0;
        rstN = 1'b0;
        fragValid = 1'b0;
        frag = '0;
        texConfig = '0;
        passCount = 0;
        failCount = 0;
        errorCount = 0;
        testsLoaded = 1'b0;
        lfsrState = 32'h0fd14e27;

        readTests();
        numTests = tests.size();
        testsLoaded = 1'b1;
        if (numTests == 0)
        begin
            $display("No test vectors were loaded");
            errorCount++;
        end

        // Strobes during reset must never reach the output
        resetOk = 1'b1;
        for (int c = 0; c < 10; c++)
        begin
            @(negedge aclk);
            fragValid = (c >= 2 && c <= 5);
            if (texelValid !== 1'b0)
            begin
                resetOk = 1'b0;
            end
        end
        fragValid = 1'b0;
        rstN = 1'b1;
        if (resetOk)
        begin
            $display("Reset test passed, texelValid stayed low");
        end
        else
        begin
            $display("Reset test failed, texelValid rose while rstN was low");
            errorCount++;
        end

        for (int i = 0; i < numTests; i++)
        begin
            // Configuration is a level, let the pipeline drain first
            if (tests[i].cfg != texConfig)
            begin
                @(negedge aclk);
                fragValid = 1'b0;
                while (expectQ.size() != 0)
                begin
                    @(posedge aclk);
                end
            end
            @(negedge aclk);
            texConfig = tests[i].cfg;
            frag = tests[i].frag;
            fragValid = 1'b1;
            expectQ.push_back('{index: 16'(i + 1), result: tests[i].expected});

            // About one idle cycle in four
            drawRandomBit(gapA);
            drawRandomBit(gapB);
            if (gapA && gapB)
            begin
                @(negedge aclk);
                fragValid = 1'b0;
            end
        end
        @(negedge aclk);
        fragValid = 1'b0;
        repeat (4) @(negedge aclk);

        if (expectQ.size() != 0)
        begin
            $display("%0d results never appeared on texelValid", expectQ.size());
            errorCount++;
        end

        if (texelAddressUnit_inst.texelAddressUnit_props_inst.assertFails != 0)
        begin
            $display("%0d concurrent assertion failures on the DUT",
                texelAddressUnit_inst.texelAddressUnit_props_inst.assertFails);
            errorCount += texelAddressUnit_inst.texelAddressUnit_props_inst.assertFails;
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d other errors",
            passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0 && passCount == numTests)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/texelAddressUnit_props.sv
`timescale 1ns/1ps
/*
 Concurrent checks bound onto the texel addressing unit.
 Strobe timing assumes the fixed two cycle latency and no back-pressure.
 Range limits assume a 256x256 chain at most.
*/
module texelAddressUnit_props
(
    input logic                     aclk,
    input logic                     rstN,
    input logic                     fragValid,
    input logic                     texelValid,
    input texturePkg::texelResult_t texel
);
    import texturePkg::*;

    // Failed assertions so far, feeds the closing verdict
    int assertFails = 0;

    // Every fragment leaves exactly two edges later
    assert property (@(posedge aclk) disable iff (!rstN)
        fragValid |-> ##2 texelValid)
    else
    begin
        assertFails++;
        $error("texelValid not seen two cycles after fragValid");
    end

    // Valid pipe is cleared by reset
    assert property (@(posedge aclk)
        !rstN |-> !texelValid)
    else
    begin
        assertFails++;
        $error("texelValid high while rstN is low");
    end

    // Level never deeper than a 1x1 level of the largest texture
    assert property (@(posedge aclk) disable iff (!rstN)
        texelValid |-> (texel.lod <= 4'(maxLod)))
    else
    begin
        assertFails++;
        $error("texel.lod above the deepest level");
    end

    // Full chain is (4**9 - 1) / 3 texels
    assert property (@(posedge aclk) disable iff (!rstN)
        texelValid |-> (texel.address < texAddrWidth'(((1 << (2 * maxLod + 2)) - 1) / 3)))
    else
    begin
        assertFails++;
        $error("texel.address beyond the end of the mip chain");
    end

endmodule

// File: logic/texelAddressUnit.sv
`timescale 1ns/1ps
/*
 Mipmap texel addressing, fixed latency of two cycles, no back-pressure.
 texConfig is a level and must not change while fragments are in flight.
 texel is valid only in the cycle of texelValid.
*/
module texelAddressUnit
(
    input  logic                       aclk,
    input  logic                       rstN,
    input  logic                       fragValid,
    input  texturePkg::texFragment_t   frag,
    input  texturePkg::textureConfig_t texConfig,
    output logic                       texelValid,
    output texturePkg::texelResult_t   texel
);
    import texturePkg::*;

    // Stage 1 results
    logic [3:0]  lod;
    texelCoord_t texelCoord;

    // One bit per pipeline stage
    logic [1:0]  validPipe;

    // Level from the neighbour step
    lodCalculator lodCalculator_inst
    (
        .aclk       (aclk),
        .rstN       (rstN),
        .widthLog2  (texConfig.widthLog2),
        .heightLog2 (texConfig.heightLog2),
        .frag       (frag),
        .lod        (lod)
    );

    // Texel grid position of the rendered pixel, same cycle
    texelCoordinate texelCoordinate_inst
    (
        .aclk       (aclk),
        .rstN       (rstN),
        .st         (frag.st),
        .texConfig  (texConfig),
        .texelCoord (texelCoord)
    );

    mipAddress mipAddress_inst
    (
        .aclk       (aclk),
        .rstN       (rstN),
        .lod        (lod),
        .texelCoord (texelCoord),
        .texConfig  (texConfig),
        .texel      (texel)
    );

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe <= {validPipe[0], fragValid};
        end
    end

    assign texelValid = validPipe[1];

endmodule

// File: logic/mipAddress.sv
`timescale 1ns/1ps
/*
 Linear texel address in a mip chain stored level after level, largest first.
 The level is clamped to the last level that exists (1x1).
 One cycle of latency after the coordinate and level stages.
*/
module mipAddress
(
    input  logic                       aclk,
    input  logic                       rstN,
    input  logic [3:0]                 lod,
    input  texturePkg::texelCoord_t    texelCoord,
    input  texturePkg::textureConfig_t texConfig,
    output texturePkg::texelResult_t   texel
);
    import texturePkg::*;

    logic [3:0]              maxSizeLog;
    logic [3:0]              level;
    logic [3:0]              levelWLog;
    logic [texelBits-1:0]    levelU;
    logic [texelBits-1:0]    levelV;
    logic [texAddrWidth-1:0] levelBase;
    logic [texAddrWidth-1:0] rowOffset;
    texelResult_t            texelNext;

    // Side log of an axis at a given level, never below 1 texel
    function automatic logic [3:0] shrinkLog
    (
        input logic [3:0] sizeLog2,
        input logic [3:0] lvl
    );
        return (sizeLog2 > lvl) ? (sizeLog2 - lvl) : 4'd0;
    endfunction

    // Texel count of one level
    function automatic logic [texAddrWidth-1:0] levelSize
    (
        input logic [3:0] widthLog2,
        input logic [3:0] heightLog2,
        input logic [3:0] lvl
    );
        logic [4:0] areaLog;

        // 8 + 8 needs the fifth bit
        areaLog = {1'b0, shrinkLog(widthLog2, lvl)} + {1'b0, shrinkLog(heightLog2, lvl)};
        return texAddrWidth'(1) << areaLog;
    endfunction

    always_comb
    begin
        // Last level is reached when the longer side is 1
        maxSizeLog = (texConfig.widthLog2 > texConfig.heightLog2) ?
            texConfig.widthLog2 : texConfig.heightLog2;
        level = (lod < maxSizeLog) ? lod : maxSizeLog;

        levelWLog = shrinkLog(texConfig.widthLog2, level);

        // u stays below the width, so a deeper shift leaves zero
        levelU = texelCoord.u >> level;
        levelV = texelCoord.v >> level;

        // Sum of all levels stored before this one
        levelBase = '0;
        for (int k = 0; k < maxLod; k++)
        begin
            if (4'(k) < level)
            begin
                levelBase = levelBase +
                    levelSize(texConfig.widthLog2, texConfig.heightLog2, 4'(k));
            end
        end

        // Row major inside the level
        rowOffset = texAddrWidth'(levelV) << levelWLog;

        texelNext.lod = level;
        texelNext.address = levelBase + rowOffset + texAddrWidth'(levelU);
    end

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            texel <= '0;
        end
        else
        begin
            texel <= texelNext;
        end
    end

endmodule

// File: logic/texelCoordinate.sv
`timescale 1ns/1ps
/*
 Maps S16.15 texture coordinates onto the level 0 texel grid.
 Repeat or clamp is chosen per axis from the configuration.
 One cycle of latency, configuration must be stable meanwhile.
*/
module texelCoordinate
(
    input  logic                       aclk,
    input  logic                       rstN,
    input  texturePkg::texCoord_t      st,
    input  texturePkg::textureConfig_t texConfig,
    output texturePkg::texelCoord_t    texelCoord
);
    import texturePkg::*;

    texelCoord_t texelNext;

    // One axis, same rule for s and t
    function automatic logic [texelBits-1:0] wrapAxis
    (
        input logic [31:0] coord,
        input logic [3:0]  sizeLog2,
        input logic        clamp
    );
        logic [3:0]           shift;
        logic [texelBits-1:0] scaled;
        logic [texelBits-1:0] lastTexel;
        logic                 negative;
        logic                 aboveOne;

        shift = 4'(maxSizeLog2) - sizeLog2;

        // Top sizeLog2 fraction bits, right aligned
        scaled = coord[fracBits-1 -: texelBits] >> shift;

        // Side minus one
        lastTexel = {texelBits{1'b1}} >> shift;

        // Sign bit, and any integer bit set on a positive value
        negative = coord[31];
        aboveOne = !negative && (|coord[30:fracBits]);

        if (clamp && negative)
        begin
            return '0;
        end
        else if (clamp && aboveOne)
        begin
            return lastTexel;
        end
        // Repeat drops the integer part
        return scaled;
    endfunction

    always_comb
    begin
        texelNext.u = wrapAxis(st.s, texConfig.widthLog2, texConfig.clampS);
        texelNext.v = wrapAxis(st.t, texConfig.heightLog2, texConfig.clampT);
    end

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            texelCoord <= '0;
        end
        else
        begin
            texelCoord <= texelNext;
        end
    end

endmodule

// File: logic/lodCalculator.sv
`timescale 1ns/1ps
/*
 Level of detail from the coordinate step between two neighbouring pixels.
 The neighbour must be one step in x and one in y in screen space.
 One cycle of latency, a new fragment may enter every cycle.
*/
module lodCalculator
(
    input  logic                     aclk,
    input  logic                     rstN,
    input  logic [3:0]               widthLog2,
    input  logic [3:0]               heightLog2,
    input  texturePkg::texFragment_t frag,
    output logic [3:0]               lod
);
    import texturePkg::*;

    logic [31:0]          diffS;
    logic [31:0]          diffT;
    logic [31:0]          absS;
    logic [31:0]          absT;
    logic [3:0]           shiftU;
    logic [3:0]           shiftV;
    logic [texelBits-1:0] spanU;
    logic [texelBits-1:0] spanV;
    logic [texelBits-1:0] spanMax;
    logic [3:0]           lodNext;

    always_comb
    begin
        // Step between the pixel and its neighbour
        diffS = frag.st.s - frag.stXy.s;
        diffT = frag.st.t - frag.stXy.t;
        absS = diffS[31] ? (~diffS + 32'd1) : diffS;
        absT = diffT[31] ? (~diffT + 32'd1) : diffT;

        // Top fraction bits give the step in texels of a 256 side
        shiftU = 4'(maxSizeLog2) - widthLog2;
        shiftV = 4'(maxSizeLog2) - heightLog2;
        spanU = absS[fracBits-1 -: texelBits] >> shiftU;
        spanV = absT[fracBits-1 -: texelBits] >> shiftV;

        // Footprint follows the wider axis
        spanMax = (spanU < spanV) ? spanV : spanU;

        // Highest set bit plus one, zero when no step at all
        lodNext = '0;
        for (int i = 0; i < texelBits; i++)
        begin
            if (spanMax[i])
            begin
                lodNext = 4'(i + 1);
            end
        end
    end

    always_ff @(posedge aclk or negedge rstN)
    begin
        if (!rstN)
        begin
            lod <= '0;
        end
        else
        begin
            lod <= lodNext;
        end
    end

endmodule

// File: logic/texturePkg.sv
/*
 Shared texture constants and the structs that carry fragments and results.
 Texture sides are powers of two from 1 to 256 texels.
 Coordinates are S16.15 fixed point.
*/
package texturePkg;

    // Largest side is 2**8 texels
    localparam int maxSizeLog2 = 8;
    // Deepest mip level of a 256x256 texture
    localparam int maxLod = maxSizeLog2;
    // Full 256x256 chain holds 87381 texels
    localparam int texAddrWidth = 17;
    // Fraction bits of an S16.15 coordinate
    localparam int fracBits = 15;
    // Texel coordinate width at full resolution
    localparam int texelBits = maxSizeLog2;

    // One texture coordinate pair, both S16.15
    typedef struct packed {
        logic [31:0] s;
        logic [31:0] t;
    } texCoord_t;

    // Rendered pixel and its neighbour one step in x and y
    typedef struct packed {
        texCoord_t st;
        texCoord_t stXy;
    } texFragment_t;

    // Held as a level while fragments are in flight
    typedef struct packed {
        logic [3:0] widthLog2;
        logic [3:0] heightLog2;
        logic       clampS;
        logic       clampT;
    } textureConfig_t;

    // Integer texel position at level 0
    typedef struct packed {
        logic [texelBits-1:0] u;
        logic [texelBits-1:0] v;
    } texelCoord_t;

    // Clamped level and linear address in the mip chain
    typedef struct packed {
        logic [3:0]              lod;
        logic [texAddrWidth-1:0] address;
    } texelResult_t;

endpackage
